// File: hw/fp_pipe_consts.svh
`ifndef FP_PIPE_CONSTS_SVH
`define FP_PIPE_CONSTS_SVH

// Width of an FP register number
// The F extension has 32 registers, f0 through f31
`define FP_REG_W 5

// Codes for the MEM_TYPE parameter

// Block RAM or cache returns load data one cycle late, so it is ready at WB
`define MEM_TYPE_BRAM 0

// Asynchronous SRAM returns load data within the MEM stage
`define MEM_TYPE_SRAM 1

`endif

// File: hw/fp_isa_pkg.sv
package fp_isa_pkg;

  // FP operation code as presented by the ID stage
  // Only the properties that matter for hazards are encoded here
  // The full instruction decode lives elsewhere in the core
  typedef enum logic [2:0] {
    // Bubble or a non-FP instruction
    FP_NOP     = 3'd0,

    // Load word into rd, reads only the integer base register
    FP_FLW     = 3'd1,

    // Store word from rs2, writes nothing in the FP file
    FP_FSW     = 3'd2,

    // Two-operand compute ops, result ready at the end of EX
    FP_FADD    = 3'd3,
    FP_FMUL    = 3'd4,

    // Fused multiply-add is the only op that reads rs3
    FP_FMADD   = 3'd5,

    // Move from an integer register into an FP register
    // The integer source is covered by the integer hazard unit
    FP_FMV_W_X = 3'd6,

    // Move from an FP register into an integer register
    // The destination is integer, so no FP write takes place
    FP_FMV_X_W = 3'd7
  } fp_op_e;

endpackage

// File: hw/fp_pipe_pkg.sv
package fp_pipe_pkg;

  // Source of an FP operand at the input of EX
  // The datapath mux uses this to pick between the register file
  // and the results still travelling down the pipeline
  typedef enum logic [1:0] {
    // Value read from the FP register file in ID
    FWD_NONE = 2'b00,

    // Compute result of the instruction currently in EX
    FWD_EX   = 2'b01,

    // Result held in MEM, either computed or loaded from SRAM
    FWD_MEM  = 2'b10
  } fwd_sel_e;

endpackage

// File: hw/fp_src_decode.sv
module fp_src_decode (
  input  fp_isa_pkg::fp_op_e op,
  output logic               rs1_used,
  output logic               rs2_used,
  output logic               rs3_used,
  output logic               fp_write,
  output logic               is_load
);

  import fp_isa_pkg::*;

  // Pure decode of the ID opcode into FP register usage
  // Every flag starts cleared so an unlisted code behaves as a no-op
  always_comb begin
    rs1_used = 1'b0;
    rs2_used = 1'b0;
    rs3_used = 1'b0;
    fp_write = 1'b0;
    is_load  = 1'b0;

    case (op)
      FP_FLW: begin
        // The address comes from an integer register
        fp_write = 1'b1;
        is_load  = 1'b1;
      end

      FP_FSW: begin
        // Only the store data is an FP source
        rs2_used = 1'b1;
      end

      FP_FADD, FP_FMUL: begin
        rs1_used = 1'b1;
        rs2_used = 1'b1;
        fp_write = 1'b1;
      end

      FP_FMADD: begin
        // The addend is the third source
        rs1_used = 1'b1;
        rs2_used = 1'b1;
        rs3_used = 1'b1;
        fp_write = 1'b1;
      end

      FP_FMV_W_X: begin
        // Integer source, FP destination
        fp_write = 1'b1;
      end

      FP_FMV_X_W: begin
        // FP source, integer destination
        rs1_used = 1'b1;
      end

      default: begin
        // FP_NOP and anything unexpected leave all flags clear
      end
    endcase
  end

endmodule

// File: hw/fp_dest_track.sv
`include "fp_pipe_consts.svh"

module fp_dest_track (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 stall,
  input  logic                 flush,

  // Decoded destination of the instruction in ID
  input  logic [`FP_REG_W-1:0] rd_id,
  input  logic                 fp_write_id,
  input  logic                 is_load_id,

  // Destination state of the EX stage
  output logic [`FP_REG_W-1:0] rd_ex,
  output logic                 reg_write_ex,
  output logic                 is_load_ex,

  // Destination state of the MEM stage
  output logic [`FP_REG_W-1:0] rd_mem,
  output logic                 reg_write_mem,
  output logic                 is_load_mem,

  // Destination state of the WB stage
  output logic [`FP_REG_W-1:0] rd_wb,
  output logic                 reg_write_wb
);

  // EX takes a bubble instead of the ID instruction on either request
  // A stall holds the instruction in ID for another try next cycle
  // A flush discards it entirely
  logic bubble_ex;

  assign bubble_ex = stall || flush;

  // Stage flags
  // Reset clears them so that no stage counts as a producer
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      reg_write_ex  <= 1'b0;
      is_load_ex    <= 1'b0;
      reg_write_mem <= 1'b0;
      is_load_mem   <= 1'b0;
      reg_write_wb  <= 1'b0;
    end else begin
      // A bubble carries no write and no load
      reg_write_ex  <= fp_write_id && !bubble_ex;
      is_load_ex    <= is_load_id && !bubble_ex;

      // Older stages always advance, which drains the pipe under a stall
      reg_write_mem <= reg_write_ex;
      is_load_mem   <= is_load_ex;
      reg_write_wb  <= reg_write_mem;
    end
  end

  // Destination register numbers
  // The number moves along even in a bubble since the cleared write flag
  // already keeps it from matching anything
  always_ff @(posedge clk) begin
    rd_ex  <= rd_id;
    rd_mem <= rd_ex;
    rd_wb  <= rd_mem;
  end

  // WB keeps no load flag
  // By the time a load reaches WB its data is on the write port, and
  // the register file bypass or the WB stall handles it like any result

endmodule

// File: hw/fp_hazard.sv
`include "fp_pipe_consts.svh"

module fp_hazard #(
  parameter int FWD_FP      = 1,
  parameter int FWD_REGFILE = 1,
  parameter int MEM_TYPE    = `MEM_TYPE_BRAM
) (
  // FP sources of the instruction in ID
  input  logic [`FP_REG_W-1:0] fp_rs1_id,
  input  logic [`FP_REG_W-1:0] fp_rs2_id,
  input  logic [`FP_REG_W-1:0] fp_rs3_id,
  input  logic                 fp_rs1_used_id,
  input  logic                 fp_rs2_used_id,
  input  logic                 fp_rs3_used_id,

  // Producer in EX
  input  logic [`FP_REG_W-1:0] fp_rd_ex,
  input  logic                 fp_reg_write_ex,
  input  logic                 is_fp_load_ex,

  // Producer in MEM
  input  logic [`FP_REG_W-1:0] fp_rd_mem,
  input  logic                 fp_reg_write_mem,
  input  logic                 is_fp_load_mem,

  // Producer in WB
  input  logic [`FP_REG_W-1:0] fp_rd_wb,
  input  logic                 fp_reg_write_wb,

  // A flush kills the ID instruction, so it must not stall
  input  logic                 control_flush,

  output logic                 fp_data_hazard_id
);

  // RAW match of any used ID source against one producing stage
  // A stage that does not write the FP file never matches
  function automatic logic src_match(input logic [`FP_REG_W-1:0] rd,
                                     input logic                 reg_write);
    logic m1;
    logic m2;
    logic m3;

    m1 = fp_rs1_used_id && (rd == fp_rs1_id);
    m2 = fp_rs2_used_id && (rd == fp_rs2_id);
    m3 = fp_rs3_used_id && (rd == fp_rs3_id);
    return reg_write && (m1 || m2 || m3);
  endfunction

  logic ex_hazard;
  logic mem_hazard;
  logic wb_hazard;

  assign ex_hazard  = src_match(fp_rd_ex, fp_reg_write_ex);
  assign mem_hazard = src_match(fp_rd_mem, fp_reg_write_mem);

  // The WB comparison only exists without the register file bypass
  // With the bypass, ID reads the value that WB is writing this cycle
  assign wb_hazard  = (FWD_REGFILE == 0) && src_match(fp_rd_wb, fp_reg_write_wb);

  // Load-use cases that forwarding cannot cover
  // A load in EX has no data yet with either memory type
  logic load_use_ex;
  logic load_use_mem;

  assign load_use_ex  = is_fp_load_ex && ex_hazard;

  // Block RAM data shows up only at WB, so a load in MEM also stalls
  // SRAM data is already in MEM and the forwarding unit picks it up there
  assign load_use_mem = (MEM_TYPE == `MEM_TYPE_BRAM) && is_fp_load_mem && mem_hazard;

  // Stall conditions for the two pipeline configurations
  logic fwd_stall;
  logic raw_stall;

  // With forwarding, compute results in EX and MEM go straight to the operand
  // muxes, leaving only the load-use and WB cases
  assign fwd_stall = load_use_ex || load_use_mem || wb_hazard;

  // Without forwarding every pending write to a used source has to drain
  // The stall lasts until the producer leaves the last compared stage
  assign raw_stall = ex_hazard || mem_hazard || wb_hazard;

  // The flush overrides everything because the ID instruction is dropped
  assign fp_data_hazard_id = ((FWD_FP != 0) ? fwd_stall : raw_stall) && !control_flush;

endmodule

// File: hw/fp_fwd_select.sv
`include "fp_pipe_consts.svh"

module fp_fwd_select #(
  parameter int MEM_TYPE = `MEM_TYPE_BRAM
) (
  // FP sources of the instruction in ID
  input  logic [`FP_REG_W-1:0] rs1,
  input  logic [`FP_REG_W-1:0] rs2,
  input  logic [`FP_REG_W-1:0] rs3,
  input  logic                 rs1_used,
  input  logic                 rs2_used,
  input  logic                 rs3_used,

  // Producer in EX
  input  logic [`FP_REG_W-1:0] rd_ex,
  input  logic                 reg_write_ex,
  input  logic                 is_load_ex,

  // Producer in MEM
  input  logic [`FP_REG_W-1:0] rd_mem,
  input  logic                 reg_write_mem,
  input  logic                 is_load_mem,

  output fp_pipe_pkg::fwd_sel_e fwd_rs1_sel,
  output fp_pipe_pkg::fwd_sel_e fwd_rs2_sel,
  output fp_pipe_pkg::fwd_sel_e fwd_rs3_sel
);

  import fp_pipe_pkg::*;

  // Select for one source, checking the youngest producer first
  // EX only forwards compute results since a load there has no data yet
  // MEM forwards a load only when SRAM returned the data in that stage
  function automatic fwd_sel_e pick(input logic [`FP_REG_W-1:0] rs,
                                    input logic                 used);
    logic ex_ok;
    logic mem_ok;

    ex_ok  = reg_write_ex && !is_load_ex && (rd_ex == rs);
    mem_ok = reg_write_mem && (rd_mem == rs) &&
             (!is_load_mem || (MEM_TYPE == `MEM_TYPE_SRAM));

    if (!used) begin
      return FWD_NONE;
    end else if (ex_ok) begin
      return FWD_EX;
    end else if (mem_ok) begin
      return FWD_MEM;
    end
    return FWD_NONE;
  endfunction

  assign fwd_rs1_sel = pick(rs1, rs1_used);
  assign fwd_rs2_sel = pick(rs2, rs2_used);
  assign fwd_rs3_sel = pick(rs3, rs3_used);

endmodule

// File: hw/fp_hazard_top.sv
`include "fp_pipe_consts.svh"

module fp_hazard_top #(
  parameter int FWD_FP      = 1,
  parameter int FWD_REGFILE = 1,
  parameter int MEM_TYPE    = `MEM_TYPE_BRAM
) (
  input  logic                  clk,
  input  logic                  rst_n,

  // Instruction in ID
  input  fp_isa_pkg::fp_op_e    op_id,
  input  logic [`FP_REG_W-1:0]  rs1_id,
  input  logic [`FP_REG_W-1:0]  rs2_id,
  input  logic [`FP_REG_W-1:0]  rs3_id,
  input  logic [`FP_REG_W-1:0]  rd_id,
  input  logic                  control_flush,

  output logic                  fp_data_hazard_id,
  output fp_pipe_pkg::fwd_sel_e fwd_rs1_sel,
  output fp_pipe_pkg::fwd_sel_e fwd_rs2_sel,
  output fp_pipe_pkg::fwd_sel_e fwd_rs3_sel
);

  import fp_pipe_pkg::*;

  // Decoded usage of the ID instruction
  logic rs1_used_id;
  logic rs2_used_id;
  logic rs3_used_id;
  logic fp_write_id;
  logic is_load_id;

  // Producer state of the later stages
  logic [`FP_REG_W-1:0] rd_ex;
  logic [`FP_REG_W-1:0] rd_mem;
  logic [`FP_REG_W-1:0] rd_wb;
  logic                 reg_write_ex;
  logic                 reg_write_mem;
  logic                 reg_write_wb;
  logic                 is_load_ex;
  logic                 is_load_mem;

  fp_src_decode u_decode (
    .op       (op_id),
    .rs1_used (rs1_used_id),
    .rs2_used (rs2_used_id),
    .rs3_used (rs3_used_id),
    .fp_write (fp_write_id),
    .is_load  (is_load_id)
  );

  // The stall feeds back here so that EX receives a bubble while ID holds
  fp_dest_track u_track (
    .clk           (clk),
    .rst_n         (rst_n),
    .stall         (fp_data_hazard_id),
    .flush         (control_flush),
    .rd_id         (rd_id),
    .fp_write_id   (fp_write_id),
    .is_load_id    (is_load_id),
    .rd_ex         (rd_ex),
    .reg_write_ex  (reg_write_ex),
    .is_load_ex    (is_load_ex),
    .rd_mem        (rd_mem),
    .reg_write_mem (reg_write_mem),
    .is_load_mem   (is_load_mem),
    .rd_wb         (rd_wb),
    .reg_write_wb  (reg_write_wb)
  );

  fp_hazard #(
    .FWD_FP      (FWD_FP),
    .FWD_REGFILE (FWD_REGFILE),
    .MEM_TYPE    (MEM_TYPE)
  ) u_hazard (
    .fp_rs1_id         (rs1_id),
    .fp_rs2_id         (rs2_id),
    .fp_rs3_id         (rs3_id),
    .fp_rs1_used_id    (rs1_used_id),
    .fp_rs2_used_id    (rs2_used_id),
    .fp_rs3_used_id    (rs3_used_id),
    .fp_rd_ex          (rd_ex),
    .fp_reg_write_ex   (reg_write_ex),
    .is_fp_load_ex     (is_load_ex),
    .fp_rd_mem         (rd_mem),
    .fp_reg_write_mem  (reg_write_mem),
    .is_fp_load_mem    (is_load_mem),
    .fp_rd_wb          (rd_wb),
    .fp_reg_write_wb   (reg_write_wb),
    .control_flush     (control_flush),
    .fp_data_hazard_id (fp_data_hazard_id)
  );

  if (FWD_FP != 0) begin : g_fwd
    fp_fwd_select #(
      .MEM_TYPE (MEM_TYPE)
    ) u_fwd (
      .rs1           (rs1_id),
      .rs2           (rs2_id),
      .rs3           (rs3_id),
      .rs1_used      (rs1_used_id),
      .rs2_used      (rs2_used_id),
      .rs3_used      (rs3_used_id),
      .rd_ex         (rd_ex),
      .reg_write_ex  (reg_write_ex),
      .is_load_ex    (is_load_ex),
      .rd_mem        (rd_mem),
      .reg_write_mem (reg_write_mem),
      .is_load_mem   (is_load_mem),
      .fwd_rs1_sel   (fwd_rs1_sel),
      .fwd_rs2_sel   (fwd_rs2_sel),
      .fwd_rs3_sel   (fwd_rs3_sel)
    );
  end else begin : g_no_fwd
    // Every operand comes from the register file
    // The hazard unit stalls until each producer has been written back
    assign fwd_rs1_sel = FWD_NONE;
    assign fwd_rs2_sel = FWD_NONE;
    assign fwd_rs3_sel = FWD_NONE;
  end

endmodule

// File: dv/fp_hazard_assertions.sv
module fp_hazard_assertions (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  control_flush,
  input logic                  fp_data_hazard_id,
  input logic                  is_load_ex,
  input fp_pipe_pkg::fwd_sel_e fwd_rs1_sel,
  input fp_pipe_pkg::fwd_sel_e fwd_rs2_sel,
  input fp_pipe_pkg::fwd_sel_e fwd_rs3_sel
);

  timeunit 1ns;
  timeprecision 1ps;

  import fp_pipe_pkg::*;

  // A flushed ID instruction is dropped, so holding it would be pointless
  a_no_stall_on_flush : assert property (@(posedge clk) disable iff (!rst_n)
    control_flush |-> !fp_data_hazard_id)
    else $error("stall is high while control_flush is high");

  // A load in EX has no data yet and can never be an EX forward source
  a_no_ex_fwd_from_load : assert property (@(posedge clk) disable iff (!rst_n)
    is_load_ex |-> (fwd_rs1_sel != FWD_EX && fwd_rs2_sel != FWD_EX &&
                    fwd_rs3_sel != FWD_EX))
    else $error("EX forward selected while a load is in EX");

  // Reset clears all stage flags, so nothing is pending one cycle later
  a_idle_after_reset : assert property (@(posedge clk)
    !rst_n |=> (!fp_data_hazard_id && fwd_rs1_sel == FWD_NONE &&
                fwd_rs2_sel == FWD_NONE && fwd_rs3_sel == FWD_NONE))
    else $error("outputs active in the cycle after reset");

endmodule

bind fp_hazard_top fp_hazard_assertions u_assertions (
  .clk               (clk),
  .rst_n             (rst_n),
  .control_flush     (control_flush),
  .fp_data_hazard_id (fp_data_hazard_id),
  .is_load_ex        (is_load_ex),
  .fwd_rs1_sel       (fwd_rs1_sel),
  .fwd_rs2_sel       (fwd_rs2_sel),
  .fwd_rs3_sel       (fwd_rs3_sel)
);

// File: dv/fp_hazard_tb.sv
`include "fp_pipe_consts.svh"

module fp_hazard_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import fp_isa_pkg::*;
  import fp_pipe_pkg::*;

  localparam int RANDOM_CYCLES = 2000;
  // Twice the random run leaves room for reset and the directed sequences
  localparam int MAX_CYCLES    = 4000;

  logic                 clk;
  logic                 rst_n;
  fp_op_e               op_id;
  logic [`FP_REG_W-1:0] rs1_id;
  logic [`FP_REG_W-1:0] rs2_id;
  logic [`FP_REG_W-1:0] rs3_id;
  logic [`FP_REG_W-1:0] rd_id;
  logic                 control_flush;
  logic                 fp_data_hazard_id;
  fwd_sel_e             fwd_rs1_sel;
  fwd_sel_e             fwd_rs2_sel;
  fwd_sel_e             fwd_rs3_sel;

  // Reference pipeline state for EX and MEM
  // With the register file bypass on, WB never affects stall or selects
  logic [`FP_REG_W-1:0] m_rd_ex;
  logic [`FP_REG_W-1:0] m_rd_mem;
  logic                 m_w_ex;
  logic                 m_w_mem;
  logic                 m_ld_ex;
  logic                 m_ld_mem;

  // Results of the latest checked cycle
  logic [4:0]           id_flags;
  logic                 last_stall;
  fwd_sel_e             seen_sel1;
  fwd_sel_e             seen_sel2;
  fwd_sel_e             seen_sel3;
  int                   seen_stalls;
  int                   cycle_count;
  logic [15:0]          lfsr;

  fp_hazard_top UUT (
    .clk               (clk),
    .rst_n             (rst_n),
    .op_id             (op_id),
    .rs1_id            (rs1_id),
    .rs2_id            (rs2_id),
    .rs3_id            (rs3_id),
    .rd_id             (rd_id),
    .control_flush     (control_flush),
    .fp_data_hazard_id (fp_data_hazard_id),
    .fwd_rs1_sel       (fwd_rs1_sel),
    .fwd_rs2_sel       (fwd_rs2_sel),
    .fwd_rs3_sel       (fwd_rs3_sel)
  );

  always #50 clk = ~clk;

  // Fibonacci LFSR with taps from x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // One LFSR step per bit that is taken
  task automatic draw_bits(input int n, output logic [15:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[14:0], lfsr[0]};
    end
  endtask

  // Register usage per opcode as {rs1, rs2, rs3, fp write, load}
  function automatic logic [4:0] op_flags(input fp_op_e op);
    case (op)
      FP_FLW:          return 5'b00011;
      FP_FSW:          return 5'b01000;
      FP_FADD, FP_FMUL: return 5'b11010;
      FP_FMADD:        return 5'b11110;
      FP_FMV_W_X:      return 5'b00010;
      FP_FMV_X_W:      return 5'b10000;
      default:         return 5'b00000;
    endcase
  endfunction

  // True when a used source of the ID instruction names register rd
  function automatic logic reads_reg(input logic [`FP_REG_W-1:0] rd);
    return (id_flags[4] && rs1_id == rd) || (id_flags[3] && rs2_id == rd) ||
           (id_flags[2] && rs3_id == rd);
  endfunction

  // Youngest forwardable producer wins
  // Block RAM loads are not forwarded from MEM
  function automatic fwd_sel_e model_sel(input logic [`FP_REG_W-1:0] rs, input logic used);
    if (used && m_w_ex && !m_ld_ex && m_rd_ex == rs) begin
      return FWD_EX;
    end else if (used && m_w_mem && !m_ld_mem && m_rd_mem == rs) begin
      return FWD_MEM;
    end
    return FWD_NONE;
  endfunction

  task automatic compare(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
    if (actual !== expected) begin
      $display("ERR %0d ns: %s: got %0d, expected %0d", $time, what, actual, expected);
      $display("FAIL: see errors above");
      $fatal(1);
    end
  endtask

  // Called just after the falling edge drive, returns at the next falling edge
  task automatic run_cycle();
    logic hit_ex;
    logic hit_mem;

    #10;
    id_flags   = op_flags(op_id);
    hit_ex     = m_w_ex && m_ld_ex && reads_reg(m_rd_ex);
    hit_mem    = m_w_mem && m_ld_mem && reads_reg(m_rd_mem);
    last_stall = !control_flush && (hit_ex || hit_mem);
    compare(fp_data_hazard_id, last_stall, "stall");
    compare(fwd_rs1_sel, model_sel(rs1_id, id_flags[4]), "rs1 select");
    compare(fwd_rs2_sel, model_sel(rs2_id, id_flags[3]), "rs2 select");
    compare(fwd_rs3_sel, model_sel(rs3_id, id_flags[2]), "rs3 select");
    seen_sel1 = fwd_rs1_sel;
    seen_sel2 = fwd_rs2_sel;
    seen_sel3 = fwd_rs3_sel;
    @(posedge clk);
    // MEM always advances, EX takes a bubble on stall or flush
    m_rd_mem = m_rd_ex;
    m_w_mem  = m_w_ex;
    m_ld_mem = m_ld_ex;
    m_rd_ex  = rd_id;
    m_w_ex   = id_flags[1] && !(last_stall || control_flush);
    m_ld_ex  = id_flags[0] && !(last_stall || control_flush);
    @(negedge clk);
  endtask

  // Presents one instruction and holds it until the stall drops
  task automatic issue(input fp_op_e op, input logic [`FP_REG_W-1:0] r1,
                       input logic [`FP_REG_W-1:0] r2, input logic [`FP_REG_W-1:0] r3,
                       input logic [`FP_REG_W-1:0] rd, input logic fl);
    op_id         = op;
    rs1_id        = r1;
    rs2_id        = r2;
    rs3_id        = r3;
    rd_id         = rd;
    control_flush = fl;
    seen_stalls   = 0;
    run_cycle();
    while (last_stall) begin
      seen_stalls++;
      run_cycle();
    end
  endtask

  task automatic drain();
    repeat (3) issue(FP_NOP, 0, 0, 0, 0, 1'b0);
  endtask

  initial begin
    cycle_count = 0;
    while (cycle_count < MAX_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
    $display("FAIL: see errors above");
    $fatal(1);
  end

  initial begin
    logic [15:0] v;
    logic        held;

    clk           = 1'b0;
    rst_n         = 1'b0;
    op_id         = FP_NOP;
    rs1_id        = '0;
    rs2_id        = '0;
    rs3_id        = '0;
    rd_id         = '0;
    control_flush = 1'b0;
    lfsr          = 16'd41;
    {m_w_ex, m_w_mem, m_ld_ex, m_ld_mem} = '0;
    m_rd_ex       = '0;
    m_rd_mem      = '0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Load-use with block RAM waits for the load to reach WB
    drain();
    issue(FP_FLW, 0, 0, 0, 1, 1'b0);
    issue(FP_FADD, 1, 2, 0, 3, 1'b0);
    compare(seen_stalls, 2, "load-use stall cycles");
    compare(seen_sel1, FWD_NONE, "load-use rs1 select");

    // Compute result forwarded from EX, then from MEM one slot later
    drain();
    issue(FP_FADD, 5, 6, 0, 4, 1'b0);
    issue(FP_FMADD, 0, 0, 4, 7, 1'b0);
    compare(seen_stalls, 0, "EX forward stall cycles");
    compare(seen_sel3, FWD_EX, "EX forward rs3 select");
    issue(FP_FADD, 5, 6, 0, 4, 1'b0);
    issue(FP_FSW, 0, 0, 0, 0, 1'b0);
    issue(FP_FMADD, 0, 0, 4, 7, 1'b0);
    compare(seen_sel3, FWD_MEM, "MEM forward rs3 select");

    // EX wins when EX and MEM write the same register
    drain();
    issue(FP_FADD, 5, 6, 0, 2, 1'b0);
    issue(FP_FMUL, 5, 6, 0, 2, 1'b0);
    issue(FP_FADD, 2, 0, 0, 3, 1'b0);
    compare(seen_sel1, FWD_EX, "priority rs1 select");

    // FP_FMV_X_W writes no FP register and unused sources never match
    drain();
    issue(FP_FMV_X_W, 0, 0, 0, 2, 1'b0);
    issue(FP_FADD, 2, 2, 0, 3, 1'b0);
    compare(seen_sel1, FWD_NONE, "after FMV_X_W rs1 select");
    compare(seen_sel2, FWD_NONE, "after FMV_X_W rs2 select");
    issue(FP_FLW, 0, 0, 0, 3, 1'b0);
    issue(FP_FMV_W_X, 3, 3, 3, 5, 1'b0);
    compare(seen_stalls, 0, "unused source stall cycles");
    compare(seen_sel1, FWD_NONE, "unused source rs1 select");
    issue(FP_FSW, 3, 0, 3, 0, 1'b0);
    compare(seen_stalls, 0, "unused source behind load stall cycles");

    // A flush drops the stall at once and sends a bubble into EX
    drain();
    issue(FP_FLW, 0, 0, 0, 1, 1'b0);
    issue(FP_FADD, 1, 0, 0, 2, 1'b1);
    compare(seen_stalls, 0, "flushed load-use stall cycles");
    drain();
    issue(FP_FADD, 5, 5, 0, 6, 1'b1);
    issue(FP_FADD, 6, 0, 0, 7, 1'b0);
    compare(seen_sel1, FWD_NONE, "after flush rs1 select");

    // Random stream
    // The instruction is held while the stall is high
    held = 1'b0;
    for (int n = 0; n < RANDOM_CYCLES; n++) begin
      if (!held) begin
        draw_bits(3, v);
        op_id = fp_op_e'(v[2:0]);
        draw_bits(3, v);
        rs1_id = {2'b00, v[2:0]};
        draw_bits(3, v);
        rs2_id = {2'b00, v[2:0]};
        draw_bits(3, v);
        rs3_id = {2'b00, v[2:0]};
        draw_bits(3, v);
        rd_id = {2'b00, v[2:0]};
      end
      draw_bits(4, v);
      control_flush = (v[3:0] == 4'd0);
      run_cycle();
      held = last_stall;
    end

    $display("PASS: all tests");
    $finish;
  end

endmodule

// File: src.f
+incdir+hw
hw/fp_isa_pkg.sv
hw/fp_pipe_pkg.sv
hw/fp_src_decode.sv
hw/fp_dest_track.sv
hw/fp_hazard.sv
hw/fp_fwd_select.sv
hw/fp_hazard_top.sv
dv/fp_hazard_assertions.sv
dv/fp_hazard_tb.sv
